//--- rtl/rob_pkg.sv
`default_nettype none

package rob_pkg;

    ////////////////////////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////////////////////////

    localparam int ROB_ID_BITS = 3;
    localparam int ROB_DEPTH = 2 ** ROB_ID_BITS;
    localparam int EX_PORTS = 2;
    // Decode sees full late, so raise it three entries early
    localparam int ROB_FULL_LEVEL = ROB_DEPTH - 3;
    localparam int INST_BYTES = 4;

    typedef logic [ROB_ID_BITS-1:0] rob_id_t;
    typedef logic [ROB_ID_BITS:0]   rob_count_t;
    typedef logic [31:0]            word_t;
    typedef logic [4:0]             reg_addr_t;

    ////////////////////////////////////////////////////////////
    // Buses
    ////////////////////////////////////////////////////////////

    // Dispatch from decode where jal also sets jump
    typedef struct packed {
        logic      valid;
        logic      branch;
        logic      jump;
        logic      jal;
        logic      pred;
        word_t     target;
        word_t     pc;
        reg_addr_t rd_addr;
    } dispatch_t;

    typedef struct packed {
        logic    valid;
        rob_id_t rob_id;
        word_t   data;
    } ex_result_t;

    typedef struct packed {
        logic      valid;
        logic      done;
        logic      branch;
        logic      jump;
        logic      jal;
        logic      pred;
        word_t     target;
        word_t     pc;
        reg_addr_t rd_addr;
        word_t     rd_data;
    } rob_entry_t;

    typedef struct packed {
        logic      valid;
        rob_id_t   rob_id;
        reg_addr_t rd_addr;
        word_t     rd_data;
    } reg_wb_t;

endpackage

`default_nettype wire

//--- rtl/rob_alloc.sv
`timescale 1ns/1ps
`default_nettype none

module rob_alloc (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           dispatch_valid,
    input  logic                           retire,
    input  logic                           flush,
    output logic [rob_pkg::ROB_DEPTH-1:0]  alloc_en,
    output rob_pkg::rob_id_t               head_id,
    output logic                           rob_full
);

    rob_pkg::rob_id_t    head_q;
    rob_pkg::rob_count_t count_q;
    rob_pkg::rob_count_t count_d;

    // A dispatch and a retire in the same cycle cancel out
    always_comb begin
        case ({dispatch_valid, retire})
            2'b10:   count_d = count_q + 1'b1;
            2'b01:   count_d = count_q - 1'b1;
            default: count_d = count_q;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head_q  <= '0;
            count_q <= '0;
        end else if (flush) begin
            // Wrong path restarts the buffer empty
            head_q  <= '0;
            count_q <= '0;
        end else begin
            count_q <= count_d;
            if (dispatch_valid) begin
                head_q <= head_q + 1'b1;
            end
        end
    end

    // One-hot write strobe for the slot at the head
    always_comb begin
        alloc_en         = '0;
        alloc_en[head_q] = dispatch_valid && !flush;
    end

    assign head_id  = head_q;
    assign rob_full = count_q >= rob_pkg::rob_count_t'(rob_pkg::ROB_FULL_LEVEL);

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    // Decode has to hold off while full is up
    no_dispatch_when_full: assert property (
        @(posedge clk) disable iff (rst)
        dispatch_valid && !flush |-> !rob_full
    ) else $error("dispatch while rob_full");

    count_in_range: assert property (
        @(posedge clk) disable iff (rst)
        count_q <= rob_pkg::rob_count_t'(rob_pkg::ROB_DEPTH)
    ) else $error("occupancy above depth");

endmodule

`default_nettype wire

//--- rtl/rob_slot.sv
`timescale 1ns/1ps
`default_nettype none

module rob_slot #(
    parameter int SLOT_ID = 0
) (
    input  logic                                         clk,
    input  logic                                         rst,
    input  logic                                         alloc,
    input  rob_pkg::dispatch_t                           dispatch,
    input  rob_pkg::ex_result_t [rob_pkg::EX_PORTS-1:0]  ex_results,
    input  logic                                         clear,
    input  logic                                         flush,
    output rob_pkg::rob_entry_t                          entry
);

    logic                    valid_q;
    logic                    done_q;
    logic                    branch_q;
    logic                    jump_q;
    logic                    jal_q;
    logic                    pred_q;
    rob_pkg::word_t          target_q;
    rob_pkg::word_t          pc_q;
    rob_pkg::reg_addr_t      rd_addr_q;
    rob_pkg::word_t          rd_data_q;

    logic [rob_pkg::EX_PORTS-1:0] hit;
    logic                         hit_any;
    rob_pkg::word_t               hit_data;

    ////////////////////////////////////////////////////////////
    // Result bus match
    ////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < rob_pkg::EX_PORTS; i++) begin
            hit[i] = ex_results[i].valid && valid_q &&
                     (ex_results[i].rob_id == rob_pkg::rob_id_t'(SLOT_ID));
        end
    end

    // At most one port hits, so the order here does not matter
    always_comb begin
        hit_any  = 1'b0;
        hit_data = '0;
        for (int i = 0; i < rob_pkg::EX_PORTS; i++) begin
            if (hit[i]) begin
                hit_any  = 1'b1;
                hit_data = ex_results[i].data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
            done_q  <= 1'b0;
        end else if (flush || clear) begin
            valid_q <= 1'b0;
            done_q  <= 1'b0;
        end else if (alloc) begin
            valid_q <= 1'b1;
            done_q  <= 1'b0;
        end else if (hit_any) begin
            done_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            branch_q  <= dispatch.branch;
            jump_q    <= dispatch.jump;
            jal_q     <= dispatch.jal;
            pred_q    <= dispatch.pred;
            target_q  <= dispatch.target;
            pc_q      <= dispatch.pc;
            rd_addr_q <= dispatch.rd_addr;
        end else if (hit_any) begin
            if (jump_q) begin
                // Jumps link pc + 4 and take the computed target
                target_q  <= {hit_data[31:1], 1'b0};
                rd_data_q <= pc_q + rob_pkg::word_t'(rob_pkg::INST_BYTES);
            end else begin
                // Branch outcome sits in bit 0
                rd_data_q <= hit_data;
            end
        end
    end

    assign entry = '{valid: valid_q, done: done_q, branch: branch_q, jump: jump_q,
                     jal: jal_q, pred: pred_q, target: target_q, pc: pc_q,
                     rd_addr: rd_addr_q, rd_data: rd_data_q};

    one_port_hit: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(hit)
    ) else $error("two result ports hit slot %0d", SLOT_ID);

    no_alloc_over_live: assert property (
        @(posedge clk) disable iff (rst)
        alloc |-> !valid_q
    ) else $error("allocation into live slot %0d", SLOT_ID);

endmodule

`default_nettype wire

//--- rtl/rob_commit.sv
`timescale 1ns/1ps
`default_nettype none

module rob_commit (
    input  logic                                          clk,
    input  logic                                          rst,
    input  rob_pkg::rob_entry_t [rob_pkg::ROB_DEPTH-1:0]  entries,
    output logic                                          retire,
    output rob_pkg::rob_id_t                              tail_id,
    output logic [rob_pkg::ROB_DEPTH-1:0]                 clear_en,
    output rob_pkg::reg_wb_t                              reg_wb,
    output logic                                          branch_miss,
    output rob_pkg::word_t                                br_address
);

    rob_pkg::rob_id_t    tail_q;
    rob_pkg::rob_entry_t tail;

    logic                wb_valid_q;
    rob_pkg::rob_id_t    wb_id_q;
    rob_pkg::reg_addr_t  wb_addr_q;
    rob_pkg::word_t      wb_data_q;
    logic                miss_q;
    rob_pkg::word_t      addr_q;

    logic                miss_d;
    rob_pkg::word_t      addr_d;
    logic                taken;

    assign tail  = entries[tail_q];
    assign taken = tail.rd_data[0];

    // Nothing retires on the flush edge
    assign retire = tail.valid && tail.done && !miss_q;

    always_comb begin
        clear_en         = '0;
        clear_en[tail_q] = retire;
    end

    ////////////////////////////////////////////////////////////
    // Control flow resolution at the tail
    ////////////////////////////////////////////////////////////

    always_comb begin
        miss_d = 1'b0;
        addr_d = tail.target;
        if (tail.branch) begin
            miss_d = tail.pred != taken;
            if (!taken) begin
                addr_d = tail.pc + rob_pkg::word_t'(rob_pkg::INST_BYTES);
            end
        end else if (tail.jal) begin
            miss_d = !tail.pred;
        end else if (tail.jump) begin
            // jalr target is never predicted
            miss_d = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tail_q     <= '0;
            wb_valid_q <= 1'b0;
            miss_q     <= 1'b0;
        end else if (miss_q) begin
            tail_q     <= '0;
            wb_valid_q <= 1'b0;
            miss_q     <= 1'b0;
        end else begin
            wb_valid_q <= retire;
            miss_q     <= retire && miss_d;
            if (retire) begin
                tail_q <= tail_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (retire) begin
            wb_id_q   <= tail_q;
            wb_addr_q <= tail.rd_addr;
            wb_data_q <= tail.rd_data;
            addr_q    <= addr_d;
        end
    end

    assign reg_wb      = '{valid: wb_valid_q, rob_id: wb_id_q, rd_addr: wb_addr_q,
                           rd_data: wb_data_q};
    assign branch_miss = miss_q;
    assign br_address  = addr_q;
    assign tail_id     = tail_q;

endmodule

`default_nettype wire

//--- rtl/rob_core.sv
`timescale 1ns/1ps
`default_nettype none

module rob_core (
    input  logic                                         clk,
    input  logic                                         rst,
    input  rob_pkg::dispatch_t                           dispatch,
    input  rob_pkg::ex_result_t [rob_pkg::EX_PORTS-1:0]  ex_results,
    output logic                                         rob_full,
    output rob_pkg::reg_wb_t                             reg_wb,
    output logic                                         branch_miss,
    output rob_pkg::word_t                               br_address
);

    logic [rob_pkg::ROB_DEPTH-1:0]                alloc_en;
    logic [rob_pkg::ROB_DEPTH-1:0]                clear_en;
    rob_pkg::rob_id_t                             head_id;
    rob_pkg::rob_id_t                             tail_id;
    logic                                         retire;
    rob_pkg::rob_entry_t [rob_pkg::ROB_DEPTH-1:0] entries;

    rob_alloc rob_alloc_inst (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch.valid),
        .retire         (retire),
        .flush          (branch_miss),
        .alloc_en       (alloc_en),
        .head_id        (head_id),
        .rob_full       (rob_full)
    );

    ////////////////////////////////////////////////////////////
    // Entry array
    ////////////////////////////////////////////////////////////

    for (genvar i = 0; i < rob_pkg::ROB_DEPTH; i++) begin : g_slot
        rob_slot #(
            .SLOT_ID (i)
        ) rob_slot_inst (
            .clk        (clk),
            .rst        (rst),
            .alloc      (alloc_en[i]),
            .dispatch   (dispatch),
            .ex_results (ex_results),
            .clear      (clear_en[i]),
            .flush      (branch_miss),
            .entry      (entries[i])
        );
    end

    rob_commit rob_commit_inst (
        .clk         (clk),
        .rst         (rst),
        .entries     (entries),
        .retire      (retire),
        .tail_id     (tail_id),
        .clear_en    (clear_en),
        .reg_wb      (reg_wb),
        .branch_miss (branch_miss),
        .br_address  (br_address)
    );

    // The early full level keeps head from wrapping onto a live tail
    no_wrap: assert property (
        @(posedge clk) disable iff (rst)
        head_id == tail_id |-> !entries[tail_id].valid
    ) else $error("head wrapped onto live tail");

endmodule

`default_nettype wire

//--- bench/rob_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rob_core_tb;

    localparam int    MAX_VECS   = 64;
    localparam int    FULL_LEVEL = 5;
    localparam int    DRAIN      = 4;
    localparam string VEC_FILE   = "bench/rob_vectors.txt";

    // In-flight instruction with its slot and vector line
    typedef struct packed {
        rob_pkg::rob_id_t rob_id;
        int               vec;
    } track_t;

    logic                                        clk;
    logic                                        rst;
    rob_pkg::dispatch_t                          dispatch;
    rob_pkg::ex_result_t [rob_pkg::EX_PORTS-1:0] ex_results;
    logic                                        rob_full;
    rob_pkg::reg_wb_t                            reg_wb;
    logic                                        branch_miss;
    rob_pkg::word_t                              br_address;

    rob_pkg::dispatch_t vec_disp   [MAX_VECS];
    rob_pkg::word_t     vec_result [MAX_VECS];
    rob_pkg::word_t     vec_data   [MAX_VECS];
    logic               vec_miss   [MAX_VECS];
    rob_pkg::word_t     vec_addr   [MAX_VECS];
    int                 n_vecs;

    track_t           expect_q  [$];
    track_t           pending_q [$];
    int               next_vec;
    rob_pkg::rob_id_t head_id;
    int               occupancy;
    logic             dispatched;
    logic             miss_seen;
    logic [31:0]      lfsr;
    int               cycles;
    int               cycle_limit;

    rob_core rob_core_inst (
        .clk         (clk),
        .rst         (rst),
        .dispatch    (dispatch),
        .ex_results  (ex_results),
        .rob_full    (rob_full),
        .reg_wb      (reg_wb),
        .branch_miss (branch_miss),
        .br_address  (br_address)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            stop_with_failure();
        end
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    task automatic stop_with_failure();
        $display("TEST FAILED");
        $fatal(1, "testbench stopped on first error");
    endtask

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output int unsigned val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    task automatic read_vectors();
        int                 fd;
        int                 got;
        string              line;
        logic               br;
        logic               jp;
        logic               jl;
        logic               pr;
        logic               miss;
        rob_pkg::reg_addr_t rd;
        rob_pkg::word_t     target;
        rob_pkg::word_t     pc;
        rob_pkg::word_t     result;
        rob_pkg::word_t     data;
        rob_pkg::word_t     addr;
        n_vecs = 0;
        fd     = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the vector file %s", VEC_FILE);
            stop_with_failure();
        end else begin
            while (!$feof(fd) && n_vecs < MAX_VECS) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) != "#") begin
                    got = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h",
                                  br, jp, jl, pr, target, pc, rd, result, data, miss, addr);
                    if (got == 11) begin
                        vec_disp[n_vecs]   = '{valid: 1'b0, branch: br, jump: jp, jal: jl,
                                               pred: pr, target: target, pc: pc, rd_addr: rd};
                        vec_result[n_vecs] = result;
                        vec_data[n_vecs]   = data;
                        vec_miss[n_vecs]   = miss;
                        vec_addr[n_vecs]   = addr;
                        n_vecs++;
                    end
                end
            end
            $fclose(fd);
        end
        if (n_vecs == 0) begin
            $display("No vector lines were read from %s", VEC_FILE);
            stop_with_failure();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////

    task automatic check_reg_wb(input rob_pkg::reg_wb_t got, input rob_pkg::reg_wb_t exp);
        if (got.valid !== exp.valid || (exp.valid && got !== exp)) begin
            $display("Fail at %0t: reg_wb %0b/%0d/%0d/%h, expected %0b/%0d/%0d/%h",
                     $time, got.valid, got.rob_id, got.rd_addr, got.rd_data,
                     exp.valid, exp.rob_id, exp.rd_addr, exp.rd_data);
            stop_with_failure();
        end
    endtask

    task automatic check_redirect(input logic got_miss, input rob_pkg::word_t got_addr,
                                  input logic exp_miss, input rob_pkg::word_t exp_addr);
        if (got_miss !== exp_miss || (exp_miss && got_addr !== exp_addr)) begin
            $display("Fail at %0t: branch_miss %0b address %h, expected %0b address %h",
                     $time, got_miss, got_addr, exp_miss, exp_addr);
            stop_with_failure();
        end
    endtask

    task automatic check_full(input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail at %0t: rob_full %0b, expected %0b at occupancy %0d",
                     $time, got, exp, occupancy);
            stop_with_failure();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Scoreboard and driver on the falling edge
    ////////////////////////////////////////////////////////////

    task automatic observe_outputs();
        rob_pkg::reg_wb_t exp_wb;
        track_t           head;
        // Flush edge empties the buffer and ignores the dispatch
        if (miss_seen) begin
            occupancy = 0;
        end else begin
            occupancy = occupancy + int'(dispatched) - int'(reg_wb.valid);
        end
        if (reg_wb.valid && expect_q.size() == 0) begin
            $display("At %0t reg_wb retired rob_id %0d with nothing in flight",
                     $time, reg_wb.rob_id);
            stop_with_failure();
        end else if (reg_wb.valid) begin
            head   = expect_q.pop_front();
            exp_wb = '{valid: 1'b1, rob_id: head.rob_id,
                       rd_addr: vec_disp[head.vec].rd_addr, rd_data: vec_data[head.vec]};
            check_reg_wb(reg_wb, exp_wb);
            check_redirect(branch_miss, br_address, vec_miss[head.vec], vec_addr[head.vec]);
            if (vec_miss[head.vec]) begin
                // Younger work is on the wrong path and goes again
                expect_q.delete();
                pending_q.delete();
                next_vec = head.vec + 1;
                head_id  = '0;
            end
        end else begin
            check_redirect(branch_miss, br_address, 1'b0, '0);
        end
        check_full(rob_full, occupancy >= FULL_LEVEL);
        miss_seen = branch_miss;
    endtask

    task automatic drive_inputs();
        int unsigned pick;
        int unsigned idx;
        track_t      item;
        dispatch   = '0;
        ex_results = '0;
        dispatched = 1'b0;
        if (!branch_miss) begin
            // Results go to any older entry in random order
            for (int p = 0; p < rob_pkg::EX_PORTS; p++) begin
                draw_bits(2, pick);
                if (pending_q.size() > 0 && pick == 0) begin
                    draw_bits(3, idx);
                    idx  = idx % pending_q.size();
                    item = pending_q[idx];
                    pending_q.delete(idx);
                    ex_results[p] = '{valid: 1'b1, rob_id: item.rob_id,
                                      data: vec_result[item.vec]};
                end
            end
            draw_bits(3, pick);
            if (!rob_full && next_vec < n_vecs && pick != 0) begin
                dispatch       = vec_disp[next_vec];
                dispatch.valid = 1'b1;
                item           = '{rob_id: head_id, vec: next_vec};
                expect_q.push_back(item);
                pending_q.push_back(item);
                head_id    = head_id + 1'b1;
                next_vec   = next_vec + 1;
                dispatched = 1'b1;
            end
        end
    endtask

    initial begin
        rst         = 1'b1;
        dispatch    = '0;
        ex_results  = '0;
        lfsr        = 32'h33729f53;
        next_vec    = 0;
        head_id     = '0;
        occupancy   = 0;
        dispatched  = 1'b0;
        miss_seen   = 1'b0;
        cycles      = 0;
        cycle_limit = 0;
        read_vectors();
        cycle_limit = 40 * n_vecs + 100;
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_reg_wb(reg_wb, '0);
        check_redirect(branch_miss, br_address, 1'b0, '0);
        check_full(rob_full, 1'b0);
        rst = 1'b0;
        while (next_vec < n_vecs || expect_q.size() > 0) begin
            @(negedge clk);
            observe_outputs();
            drive_inputs();
        end
        // Idle tail catches a stray retirement or redirect
        repeat (DRAIN) begin
            @(negedge clk);
            observe_outputs();
            drive_inputs();
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- rob_core.f
rtl/rob_pkg.sv
rtl/rob_alloc.sv
rtl/rob_slot.sv
rtl/rob_commit.sv
rtl/rob_core.sv
bench/rob_core_tb.sv

//--- Makefile
# Verilator build and run for the reorder buffer testbench
VERILATOR ?= verilator
TOP       ?= rob_core_tb
FILELIST  ?= rob_core.f
OBJ_DIR   ?= obj_dir
VECTORS   ?= bench/rob_vectors.txt
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# A $fatal in the testbench gives a non-zero exit status
run: $(SIM) $(VECTORS)
	$(SIM)

clean:
	rm -rf $(OBJ_DIR)

//--- bench/rob_vectors.txt
# branch jump jal pred target pc rd_addr result | expected rd_data miss br_address
# All fields hex, br_address only matters when miss is set
0 0 0 0 00000000 00001000 01 11110001 11110001 0 00000000
0 0 0 0 00000000 00001004 02 22220002 22220002 0 00000000
1 0 0 0 00001100 00001008 00 00000000 00000000 0 00000000
0 0 0 0 00000000 0000100c 03 33330003 33330003 0 00000000
0 0 0 0 00000000 00001010 04 44440004 44440004 0 00000000
1 0 0 1 00001200 00001014 00 00000001 00000001 0 00000000
0 1 1 1 00002000 00001018 01 00002000 0000101c 0 00000000
0 0 0 0 00000000 0000101c 05 55550005 55550005 0 00000000
1 0 0 0 00001300 00001020 00 00000001 00000001 1 00001300
0 0 0 0 00000000 00001024 06 66660006 66660006 0 00000000
0 0 0 0 00000000 00001028 07 77770007 77770007 0 00000000
1 0 0 1 00001400 0000102c 00 00000000 00000000 1 00001030
0 0 0 0 00000000 00001030 08 88880008 88880008 0 00000000
0 1 0 0 00000000 00001034 01 00003001 00001038 1 00003000
0 0 0 0 00000000 00001038 09 99990009 99990009 0 00000000
0 1 1 0 00004000 0000103c 01 00004000 00001040 1 00004000
0 0 0 0 00000000 00001040 0a aaaa000a aaaa000a 0 00000000
0 0 0 0 00000000 00001044 0b bbbb000b bbbb000b 0 00000000
0 0 0 0 00000000 00001048 0c cccc000c cccc000c 0 00000000
0 0 0 0 00000000 0000104c 0d dddd000d dddd000d 0 00000000
1 0 0 1 00001500 00001050 00 00000003 00000003 0 00000000
0 0 0 0 00000000 00001054 0e eeee000e eeee000e 0 00000000
0 0 0 0 00000000 00001058 0f ffff000f ffff000f 0 00000000
0 1 0 1 00000000 0000105c 01 00005007 00001060 1 00005006
